//--- Bender.yml
package:
  name: i2c_master

sources:
  - i2c_pkg.sv
  - i2c_cmd_if.sv
  - scl_phase_gen.sv
  - i2c_bit_ctrl.sv
  - i2c_sequencer.sv
  - i2c_master.sv
  - target: simulation
    files:
      - i2c_master_checker.sv
      - tb_i2c_master.sv

//--- build.f
i2c_pkg.sv
i2c_cmd_if.sv
scl_phase_gen.sv
i2c_bit_ctrl.sv
i2c_sequencer.sv
i2c_master.sv
i2c_master_checker.sv
tb_i2c_master.sv

//--- i2c_bit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctrl import i2c_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    i2c_cmd_if.target bus,
    input  logic      sda_i,
    output logic      scl_oe_o,
    output logic      sda_oe_o
);

    // Quarter phase of SCL and its boundary pulse
    scl_phase_t           phase;
    logic                 tick;
    // Generator enable, held between commands until STOP
    logic                 run;
    // Command in progress
    logic                 active;
    // Waiting out the first quarter after the generator starts
    logic                 lead;
    bus_cmd_e             cur_cmd;
    // Bit slot of the byte, 8 is the ACK slot
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BYTE_W-1:0]    shift_q;
    // Current slot is the last one of the command
    logic                 last_bit;
    // Quarter boundary that belongs to the running command
    logic                 step;

    scl_phase_gen u_phase_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .run_i   (run),
        .phase_o (phase),
        .tick_o  (tick)
    );

    // SCL low in the first half of each period
    assign scl_oe_o = run & ((phase == PH_LOW0) | (phase == PH_LOW1));

    // START and STOP last one period, bytes nine
    assign last_bit = (cur_cmd == CMD_START) || (cur_cmd == CMD_STOP)
                      || (bit_cnt == BIT_CNT_W'(BYTE_W));

    assign step = active & tick & ~lead;

    //////////////////////////////////////////////////////////////////////
    // Command control and SDA drive
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_n) begin
            run        <= 1'b0;
            active     <= 1'b0;
            lead       <= 1'b0;
            cur_cmd    <= CMD_STOP;
            bit_cnt    <= '0;
            sda_oe_o   <= 1'b0;
            bus.done   <= 1'b0;
            bus.ack_ok <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.cmd_valid && !active) begin
                active  <= 1'b1;
                run     <= 1'b1;
                // Lead-in quarter only when the generator was stopped
                lead    <= ~run;
                cur_cmd <= bus.cmd;
                bit_cnt <= '0;
            end else if (active && tick && lead) begin
                lead <= 1'b0;
            end else if (step) begin
                case (phase)
                    // Start of the second low quarter, SDA may change
                    PH_LOW0: begin
                        case (cur_cmd)
                            CMD_START: sda_oe_o <= 1'b0;
                            CMD_STOP:  sda_oe_o <= 1'b1;
                            // MSB first, ACK slot released
                            CMD_WRITE: sda_oe_o <= last_bit ? 1'b0 : ~shift_q[BYTE_W-1];
                            // Read data and NACK, SDA left to the target
                            default:   sda_oe_o <= 1'b0;
                        endcase
                    end
                    // Middle of SCL high
                    PH_HIGH0: begin
                        if (cur_cmd == CMD_START) begin
                            // SDA falls while SCL high
                            sda_oe_o <= 1'b1;
                        end else if (cur_cmd == CMD_STOP) begin
                            // SDA rises while SCL high
                            sda_oe_o <= 1'b0;
                        end else if (cur_cmd == CMD_WRITE && last_bit) begin
                            bus.ack_ok <= ~sda_i;
                        end
                    end
                    // End of the SCL period
                    PH_HIGH1: begin
                        if (last_bit) begin
                            active   <= 1'b0;
                            bus.done <= 1'b1;
                            // Bus idle after STOP, SCL parks released
                            if (cur_cmd == CMD_STOP) begin
                                run <= 1'b0;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Byte shift register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.cmd_valid && !active) begin
            shift_q <= bus.tx_byte;
        end else if (step && cur_cmd == CMD_READ && phase == PH_HIGH0 && !last_bit) begin
            // Sample in the middle of SCL high, MSB first
            shift_q <= {shift_q[BYTE_W-2:0], sda_i};
        end else if (step && cur_cmd == CMD_WRITE && phase == PH_HIGH1 && !last_bit) begin
            shift_q <= {shift_q[BYTE_W-2:0], 1'b0};
        end
        // Received byte published with done
        if (step && cur_cmd == CMD_READ && phase == PH_HIGH1 && last_bit) begin
            bus.rx_byte <= shift_q;
        end
    end

endmodule

`default_nettype wire

//--- i2c_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i2c_cmd_if import i2c_pkg::*; ();

    // Command side, driven by the sequencer
    logic              cmd_valid;   // one-cycle strobe
    bus_cmd_e          cmd;
    logic [BYTE_W-1:0] tx_byte;

    // Result side, driven by the bit controller
    logic              done;        // one-cycle pulse at command end
    logic [BYTE_W-1:0] rx_byte;     // valid from done until next command
    logic              ack_ok;      // target pulled SDA low in the ACK slot

    // Sequencer view
    modport initiator (
        output cmd_valid, cmd, tx_byte,
        input  done, rx_byte, ack_ok
    );

    // Bit controller view
    modport target (
        input  cmd_valid, cmd, tx_byte,
        output done, rx_byte, ack_ok
    );

endinterface

`default_nettype wire

//--- i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master import i2c_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Request
    input  logic              en_i,
    input  logic              rw_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [BYTE_W-1:0] reg_addr_i,
    input  logic [BYTE_W-1:0] data_i,
    // Resolved bus lines
    input  logic              sda_i,
    input  logic              scl_i,
    // Status and read data
    output logic              busy_o,
    output logic              err_o,
    output logic [BYTE_W-1:0] data_o,
    // Open-drain enables, 1 pulls the line low
    output logic              scl_oe_o,
    output logic              sda_oe_o
);

    // Command path between sequencer and bit controller
    i2c_cmd_if cmd_bus ();

    i2c_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_i       (en_i),
        .rw_i       (rw_i),
        .addr_i     (addr_i),
        .reg_addr_i (reg_addr_i),
        .data_i     (data_i),
        .bus        (cmd_bus.initiator),
        .busy_o     (busy_o),
        .err_o      (err_o),
        .data_o     (data_o)
    );

    // SCL is only driven, no clock stretching, so scl_i stays unread here
    i2c_bit_ctrl u_bit_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (cmd_bus.target),
        .sda_i    (sda_i),
        .scl_oe_o (scl_oe_o),
        .sda_oe_o (sda_oe_o)
    );

endmodule

`default_nettype wire

//--- i2c_master_checker.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic en_i,
    input wire logic scl_i,
    input wire logic busy_o,
    input wire logic scl_oe_o,
    input wire logic sda_oe_o
);

    // Assertion failures seen so far
    int fail_cnt = 0;

    // Idle master leaves both lines released
    idle_released: assert property (@(posedge clk) disable iff (rst_n)
        !busy_o |-> (!scl_oe_o && !sda_oe_o))
        else begin
            $error("bus driven while not busy");
            fail_cnt++;
        end

    // Request taken when idle, busy follows one cycle later
    accept_sets_busy: assert property (@(posedge clk) disable iff (rst_n)
        (en_i && !busy_o) |=> busy_o)
        else begin
            $error("accepted request did not raise busy");
            fail_cnt++;
        end

    // SDA moves under high SCL only for START or STOP inside a transaction
    sda_change_in_txn: assert property (@(posedge clk) disable iff (rst_n)
        ($changed(sda_oe_o) && scl_i && $past(scl_i)) |-> busy_o)
        else begin
            $error("SDA changed while SCL high outside a transaction");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus timing
    //////////////////////////////////////////////////////////////////////

    // clk cycles per quarter SCL period, 20 clk per bit in simulation
    localparam int QUARTER_CYCLES = 5;
    // Width of the quarter counter
    localparam int QTR_CNT_W      = $clog2(QUARTER_CYCLES);

    // Address and data widths
    localparam int ADDR_W    = 7;
    localparam int BYTE_W    = 8;
    // Eight data bits plus the ACK slot
    localparam int BIT_CNT_W = $clog2(BYTE_W + 1);

    // Quarter index inside one SCL period
    typedef logic [1:0] scl_phase_t;

    // SCL pulled low in the first two quarters, released in the last two
    localparam scl_phase_t PH_LOW0  = 2'd0;
    localparam scl_phase_t PH_LOW1  = 2'd1;
    localparam scl_phase_t PH_HIGH0 = 2'd2;
    localparam scl_phase_t PH_HIGH1 = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Opcodes and states
    //////////////////////////////////////////////////////////////////////

    // Bus commands from sequencer to bit controller
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_e;

    // Transaction sequencer states, one bus command each
    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_ADDR_W,
        SEQ_REG,
        SEQ_DATA_W,
        SEQ_RESTART,
        SEQ_ADDR_R,
        SEQ_DATA_R,
        SEQ_STOP
    } seq_state_e;

endpackage

`default_nettype wire

//--- i2c_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_sequencer import i2c_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en_i,
    input  logic              rw_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [BYTE_W-1:0] reg_addr_i,
    input  logic [BYTE_W-1:0] data_i,
    i2c_cmd_if.initiator      bus,
    output logic              busy_o,
    output logic              err_o,
    output logic [BYTE_W-1:0] data_o
);

    seq_state_e        state;
    seq_state_e        nxt_state;
    bus_cmd_e          nxt_cmd;
    logic [BYTE_W-1:0] nxt_byte;

    // Latched request
    logic              rw_q;
    logic [ADDR_W-1:0] addr_q;
    logic [BYTE_W-1:0] reg_q;
    logic [BYTE_W-1:0] data_q;

    logic              accept;      // new request taken
    logic              advance;     // move to the next state
    logic              write_state; // current command sends a byte
    logic              nack;        // target did not ACK that byte

    // New requests only when idle
    assign accept  = en_i && (state == SEQ_IDLE);
    assign advance = accept || ((state != SEQ_IDLE) && bus.done);

    assign write_state = state inside {SEQ_ADDR_W, SEQ_REG, SEQ_DATA_W, SEQ_ADDR_R};
    assign nack        = write_state && !bus.ack_ok;

    //////////////////////////////////////////////////////////////////////
    // Next state and its bus command
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nxt_state = SEQ_IDLE;
        case (state)
            SEQ_IDLE:    nxt_state = en_i ? SEQ_START : SEQ_IDLE;
            SEQ_START:   nxt_state = SEQ_ADDR_W;
            SEQ_ADDR_W:  nxt_state = SEQ_REG;
            // Reads turn the bus around with a repeated START
            SEQ_REG:     nxt_state = rw_q ? SEQ_RESTART : SEQ_DATA_W;
            SEQ_DATA_W:  nxt_state = SEQ_STOP;
            SEQ_RESTART: nxt_state = SEQ_ADDR_R;
            SEQ_ADDR_R:  nxt_state = SEQ_DATA_R;
            SEQ_DATA_R:  nxt_state = SEQ_STOP;
            SEQ_STOP:    nxt_state = SEQ_IDLE;
            default:     nxt_state = SEQ_IDLE;
        endcase
        // Abort on a missing ACK
        if (nack) begin
            nxt_state = SEQ_STOP;
        end
    end

    always_comb begin
        nxt_cmd  = CMD_WRITE;
        nxt_byte = reg_q;
        case (nxt_state)
            SEQ_START,
            SEQ_RESTART: nxt_cmd  = CMD_START;
            // Address byte, R/W bit in the LSB
            SEQ_ADDR_W:  nxt_byte = {addr_q, 1'b0};
            SEQ_REG:     nxt_byte = reg_q;
            SEQ_DATA_W:  nxt_byte = data_q;
            SEQ_ADDR_R:  nxt_byte = {addr_q, 1'b1};
            SEQ_DATA_R:  nxt_cmd  = CMD_READ;
            SEQ_STOP:    nxt_cmd  = CMD_STOP;
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // State, command strobe and status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state         <= SEQ_IDLE;
            busy_o        <= 1'b0;
            err_o         <= 1'b0;
            data_o        <= '0;
            bus.cmd_valid <= 1'b0;
            bus.cmd       <= CMD_START;
        end else begin
            bus.cmd_valid <= 1'b0;
            // One command per state, strobed on entry
            if (advance) begin
                state         <= nxt_state;
                bus.cmd_valid <= (nxt_state != SEQ_IDLE);
                bus.cmd       <= nxt_cmd;
            end
            if (accept) begin
                busy_o <= 1'b1;
                err_o  <= 1'b0;
            end
            if (bus.done && nack) begin
                err_o <= 1'b1;
            end
            // Transaction ends with the STOP
            if (bus.done && (state == SEQ_STOP)) begin
                busy_o <= 1'b0;
                if (rw_q && !err_o) begin
                    data_o <= bus.rx_byte;
                end
            end
        end
    end

    // Request and outgoing byte
    always_ff @(posedge clk) begin
        if (accept) begin
            rw_q   <= rw_i;
            addr_q <= addr_i;
            reg_q  <= reg_addr_i;
            data_q <= data_i;
        end
        if (advance) begin
            bus.tx_byte <= nxt_byte;
        end
    end

endmodule

`default_nettype wire

//--- scl_phase_gen.sv
`timescale 1ns/1ps
`default_nettype none

module scl_phase_gen import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run_i,
    output scl_phase_t phase_o,
    output logic       tick_o
);

    // Clocks spent in the current quarter
    logic [QTR_CNT_W-1:0] qtr_cnt;
    // Last clock of a quarter
    logic                 qtr_end;

    assign qtr_end = (qtr_cnt == QTR_CNT_W'(QUARTER_CYCLES - 1));

    // One pulse per quarter boundary, only while running
    assign tick_o = run_i & qtr_end;

    //////////////////////////////////////////////////////////////////////
    // Quarter counter and phase
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Stopped generator parks in the last high quarter
        // so SCL stays released
        if (rst_n || !run_i) begin
            qtr_cnt <= '0;
            phase_o <= PH_HIGH1;
        end else if (qtr_end) begin
            qtr_cnt <= '0;
            // Wraps from the last high quarter back to SCL low
            phase_o <= phase_o + 2'd1;
        end else begin
            qtr_cnt <= qtr_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

    localparam logic [ADDR_W-1:0] TGT_ADDR = 7'h50;
    localparam logic [ADDR_W-1:0] BAD_ADDR = 7'h23;
    localparam int TIMEOUT_CYCLES = 40 * 40 * 9 * 4 * QUARTER_CYCLES;
    // Target model modes
    localparam int M_IDLE = 0;
    localparam int M_ADDR = 1;
    localparam int M_REG = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic clk;
    logic rst_n;
    logic en_i;
    logic rw_i;
    logic [ADDR_W-1:0] addr_i;
    logic [BYTE_W-1:0] reg_addr_i;
    logic [BYTE_W-1:0] data_i;
    logic busy_o;
    logic err_o;
    logic [BYTE_W-1:0] data_o;
    logic scl_oe_o;
    logic sda_oe_o;

    // Wired-AND bus with pull-ups
    logic tgt_sda_oe;
    wire scl_line;
    wire sda_line;
    assign scl_line = !scl_oe_o;
    assign sda_line = !(sda_oe_o || tgt_sda_oe);

    // Target model state
    logic [BYTE_W-1:0] tgt_regs [256];
    logic [BYTE_W-1:0] ref_regs [256];
    logic [BYTE_W-1:0] ref_data;
    logic [BYTE_W-1:0] shift_in;
    logic [BYTE_W-1:0] rd_byte;
    logic [BYTE_W-1:0] ptr;
    logic read_dir;
    int mode;
    int bit_cnt;

    // Expected {err, data} per request
    logic [BYTE_W:0] exp_q [$];
    int n_issued;
    int n_done;
    int errors;
    int tests_run;
    int tests_failed;
    int cycles;
    logic busy_prev;

    i2c_master uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_i       (en_i),
        .rw_i       (rw_i),
        .addr_i     (addr_i),
        .reg_addr_i (reg_addr_i),
        .data_i     (data_i),
        .sda_i      (sda_line),
        .scl_i      (scl_line),
        .busy_o     (busy_o),
        .err_o      (err_o),
        .data_o     (data_o),
        .scl_oe_o   (scl_oe_o),
        .sda_oe_o   (sda_oe_o)
    );

    bind i2c_master i2c_master_checker u_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (en_i),
        .scl_i    (scl_i),
        .busy_o   (busy_o),
        .scl_oe_o (scl_oe_o),
        .sda_oe_o (sda_oe_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Target model
    //////////////////////////////////////////////////////////////////////

    // START, SDA falls with SCL high
    always @(negedge sda_line) begin
        if (scl_line === 1'b1) begin
            mode = M_ADDR;
            bit_cnt = 0;
        end
    end

    // STOP, SDA rises with SCL high
    always @(posedge sda_line) begin
        if (scl_line === 1'b1) begin
            mode = M_IDLE;
            bit_cnt = 0;
            tgt_sda_oe = 1'b0;
        end
    end

    always @(posedge scl_line) begin
        if (mode != M_IDLE) begin
            if (mode != M_RDATA && bit_cnt < 8) begin
                shift_in = {shift_in[BYTE_W-2:0], sda_line};
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    // SDA only changes while SCL is low
    always @(negedge scl_line) begin
        if (mode == M_RDATA) begin
            if (bit_cnt < 8) begin
                tgt_sda_oe = ~rd_byte[7-bit_cnt];
            end else begin
                // Master NACKs the ninth bit
                tgt_sda_oe = 1'b0;
                mode = M_IDLE;
            end
        end else if (mode != M_IDLE && bit_cnt == 8) begin
            tgt_sda_oe = 1'b1;
            if (mode == M_ADDR) begin
                if (shift_in[7:1] != TGT_ADDR) begin
                    tgt_sda_oe = 1'b0;
                    mode = M_IDLE;
                end
                read_dir = shift_in[0];
            end else if (mode == M_REG) begin
                ptr = shift_in;
            end else begin
                tgt_regs[ptr] = shift_in;
            end
        end else if (mode != M_IDLE && bit_cnt == 9) begin
            tgt_sda_oe = 1'b0;
            bit_cnt = 0;
            if (mode == M_ADDR && read_dir) begin
                mode = M_RDATA;
                rd_byte = tgt_regs[ptr];
                tgt_sda_oe = ~rd_byte[7];
            end else if (mode == M_ADDR) begin
                mode = M_REG;
            end else begin
                mode = M_WDATA;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference and comparison
    //////////////////////////////////////////////////////////////////////

    // Expected {err, data_o}, data_o holds unless a read succeeds
    function automatic logic [BYTE_W:0] ref_result(input logic rw,
            input logic [ADDR_W-1:0] addr, input logic [BYTE_W-1:0] ra,
            input logic [BYTE_W-1:0] wd);
        logic err;
        err = (addr != TGT_ADDR);
        if (!err && rw) begin
            ref_data = ref_regs[ra];
        end else if (!err) begin
            ref_regs[ra] = wd;
        end
        return {err, ref_data};
    endfunction

    task automatic check_value(input string name, input logic [BYTE_W-1:0] got,
            input logic [BYTE_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    // Result checked once busy_o has fallen
    always @(negedge clk) begin
        logic [BYTE_W:0] exp;
        if (busy_prev && !busy_o) begin
            if (exp_q.size() == 0) begin
                $display("Transaction completed at %0t with no request pending", $time);
                errors = errors + 1;
            end else begin
                exp = exp_q.pop_front();
                check_value("err_o", {7'd0, err_o}, {7'd0, exp[BYTE_W]});
                check_value("data_o", data_o, exp[BYTE_W-1:0]);
            end
            n_done = n_done + 1;
        end
        busy_prev = busy_o;
    end

    task automatic drive_request(input logic rw, input logic [ADDR_W-1:0] addr,
            input logic [BYTE_W-1:0] ra, input logic [BYTE_W-1:0] wd);
        @(posedge clk);
        en_i <= 1'b1;
        rw_i <= rw;
        addr_i <= addr;
        reg_addr_i <= ra;
        data_i <= wd;
        @(posedge clk);
        en_i <= 1'b0;
    endtask

    task automatic run_txn(input logic rw, input logic [ADDR_W-1:0] addr,
            input logic [BYTE_W-1:0] ra, input logic [BYTE_W-1:0] wd);
        exp_q.push_back(ref_result(rw, addr, ra, wd));
        n_issued = n_issued + 1;
        drive_request(rw, addr, ra, wd);
        wait (n_done == n_issued);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (errors != errs_before) begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int e0;
        int done_before;
        logic [BYTE_W-1:0] ra;
        logic [BYTE_W-1:0] wd;
        void'($urandom(32'hf9ea_81c0));
        rst_n = 1'b1;
        en_i = 1'b0;
        rw_i = 1'b0;
        addr_i = '0;
        reg_addr_i = '0;
        data_i = '0;
        tgt_sda_oe = 1'b0;
        mode = M_IDLE;
        bit_cnt = 0;
        ptr = '0;
        read_dir = 1'b0;
        shift_in = '0;
        rd_byte = '0;
        ref_data = '0;
        n_issued = 0;
        n_done = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        busy_prev = 1'b0;
        // Preset register contents are the index inverted
        for (int i = 0; i < 256; i++) begin
            tgt_regs[i] = ~i[BYTE_W-1:0];
            ref_regs[i] = ~i[BYTE_W-1:0];
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b0;

        e0 = errors;
        @(negedge clk);
        check_value("busy_o", {7'd0, busy_o}, 8'd0);
        check_value("err_o", {7'd0, err_o}, 8'd0);
        check_value("scl_oe_o", {7'd0, scl_oe_o}, 8'd0);
        check_value("sda_oe_o", {7'd0, sda_oe_o}, 8'd0);
        check_value("data_o", data_o, 8'd0);
        finish_test("reset values", e0);

        e0 = errors;
        run_txn(1'b0, TGT_ADDR, 8'h3c, 8'ha5);
        run_txn(1'b1, TGT_ADDR, 8'h3c, 8'h00);
        finish_test("write then read", e0);

        e0 = errors;
        run_txn(1'b1, TGT_ADDR, 8'h07, 8'h00);
        finish_test("unwritten register", e0);

        e0 = errors;
        run_txn(1'b0, BAD_ADDR, 8'h3c, 8'h11);
        run_txn(1'b1, BAD_ADDR, 8'h3c, 8'h00);
        for (int i = 0; i < 256; i++) begin
            if (tgt_regs[i] !== ref_regs[i]) begin
                $display("Register %0d changed by a request to a wrong address", i);
                errors = errors + 1;
            end
        end
        run_txn(1'b1, TGT_ADDR, 8'h3c, 8'h00);
        finish_test("wrong address", e0);

        // Second request while busy must be dropped
        e0 = errors;
        exp_q.push_back(ref_result(1'b0, TGT_ADDR, 8'h10, 8'h5a));
        n_issued = n_issued + 1;
        done_before = n_done;
        drive_request(1'b0, TGT_ADDR, 8'h10, 8'h5a);
        wait (busy_o === 1'b1);
        repeat (10) @(posedge clk);
        drive_request(1'b0, TGT_ADDR, 8'h11, 8'hc3);
        wait (n_done == n_issued);
        repeat (60) @(posedge clk);
        if (n_done != done_before + 1 || busy_o !== 1'b0) begin
            $display("Request sent while busy started a transaction");
            errors = errors + 1;
        end
        run_txn(1'b1, TGT_ADDR, 8'h11, 8'h00);
        run_txn(1'b1, TGT_ADDR, 8'h10, 8'h00);
        finish_test("request while busy", e0);

        e0 = errors;
        for (int i = 0; i < 30; i++) begin
            ra = BYTE_W'($urandom());
            wd = BYTE_W'($urandom());
            run_txn(1'b0, TGT_ADDR, ra, wd);
            run_txn(1'b1, TGT_ADDR, ra, 8'h00);
        end
        finish_test("random pairs", e0);

        errors = errors + uut.u_checker.fail_cnt;
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
